//--- hdl/isa_pkg.sv
package isa_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int csr_addr_w = 14;

    // LL bit control register.
    localparam logic [csr_addr_w-1:0] csr_llbctl = 14'h060;

    // ------------------------------------------------------------------------
    // opcodes
    // ------------------------------------------------------------------------
    typedef enum logic [4:0] {
        op_or,
        op_nor,
        op_and,
        op_xor,
        op_lu12i,   // immediate already placed in reg2.
        op_sll,
        op_srl,
        op_sra,
        op_add,
        op_sub,
        op_slt,
        op_sltu,
        op_mul,
        op_mulh,
        op_mulhu,
        op_div,
        op_divu,
        op_mod,
        op_modu,
        op_ld_b,
        op_ld_bu,
        op_ld_h,
        op_ld_hu,
        op_ld_w,
        op_ll_w,
        op_st_b,
        op_st_h,
        op_st_w,
        op_sc_w,
        op_nop
    } alu_op_e;

    // result group that feeds the write-back data.
    typedef enum logic [2:0] {
        sel_logic,
        sel_shift,
        sel_arith,
        sel_load_store,
        sel_none
    } alu_sel_e;

endpackage

//--- hdl/stage_pkg.sv
package stage_pkg;

    localparam int ld_kinds = 6;                  // ld.b ld.bu ld.h ld.hu ld.w ll.w.
    localparam int st_kinds = 4;                  // st.b st.h st.w sc.w.
    localparam int strb_w   = isa_pkg::xlen / 8;

    // ------------------------------------------------------------------------
    // pipeline boundaries
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                              valid;
        logic [isa_pkg::xlen-1:0]          pc;
        logic [isa_pkg::xlen-1:0]          inst;
        isa_pkg::alu_op_e                  op;
        isa_pkg::alu_sel_e                 sel;
        logic [isa_pkg::xlen-1:0]          reg1;
        logic [isa_pkg::xlen-1:0]          reg2;
        logic                              reg_write_en;
        logic [isa_pkg::reg_addr_w-1:0]    reg_write_addr;
        logic                              is_exception;   // raised upstream.
    } dispatch_ex_t;

    typedef struct packed {
        logic                              valid;
        logic [isa_pkg::xlen-1:0]          pc;
        logic                              reg_write_en;
        logic [isa_pkg::reg_addr_w-1:0]    reg_write_addr;
        logic [isa_pkg::xlen-1:0]          reg_write_data;
        logic [isa_pkg::xlen-1:0]          mem_addr;
        logic [ld_kinds-1:0]               ld_en;
        logic [st_kinds-1:0]               st_en;          // msb is a successful sc.w.
        logic                              ale;
        logic                              llbit_we;
        logic                              llbit_wdata;
    } ex_mem_t;

    // data cache request, held until addr_ok.
    typedef struct packed {
        logic                              valid;
        logic                              op;             // 1 for store.
        logic [isa_pkg::xlen-1:0]          addr;
        logic [isa_pkg::xlen-1:0]          wdata;
        logic [strb_w-1:0]                 wstrb;
    } dcache_req_t;

    typedef struct packed {
        logic                              write_en;
        logic [isa_pkg::csr_addr_w-1:0]    write_addr;
        logic [isa_pkg::xlen-1:0]          write_data;
    } csr_fwd_t;

    // ------------------------------------------------------------------------
    // divider link
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                              start;
        logic                              is_signed;
        logic [isa_pkg::xlen-1:0]          dividend;
        logic [isa_pkg::xlen-1:0]          divisor;
    } div_req_t;

    typedef struct packed {
        logic                              done;
        logic [isa_pkg::xlen-1:0]          quotient;
        logic [isa_pkg::xlen-1:0]          remainder;
    } div_resp_t;

endpackage

//--- hdl/alu_int.sv
module alu_int (
    input  isa_pkg::alu_op_e           op,
    input  logic [isa_pkg::xlen-1:0]   reg1,
    input  logic [isa_pkg::xlen-1:0]   reg2,
    output logic [isa_pkg::xlen-1:0]   logic_res,
    output logic [isa_pkg::xlen-1:0]   shift_res,
    output logic [isa_pkg::xlen-1:0]   arith_res
);

    logic [4:0]                   shamt;
    logic                         lt_signed;
    logic                         lt_unsigned;
    logic                         mul_signed;
    logic [isa_pkg::xlen-1:0]     mag1;
    logic [isa_pkg::xlen-1:0]     mag2;
    logic [2*isa_pkg::xlen-1:0]   mag_prod;
    logic [2*isa_pkg::xlen-1:0]   prod;

    assign shamt = reg2[4:0];

    always_comb begin
        case (op)
            isa_pkg::op_or, isa_pkg::op_lu12i: logic_res = reg1 | reg2;
            isa_pkg::op_nor:                   logic_res = ~(reg1 | reg2);
            isa_pkg::op_and:                   logic_res = reg1 & reg2;
            isa_pkg::op_xor:                   logic_res = reg1 ^ reg2;
            default:                           logic_res = '0;
        endcase
    end

    always_comb begin
        case (op)
            isa_pkg::op_sll: shift_res = reg1 << shamt;
            isa_pkg::op_srl: shift_res = reg1 >> shamt;
            isa_pkg::op_sra: shift_res = $unsigned($signed(reg1) >>> shamt);
            default:         shift_res = '0;
        endcase
    end

    assign lt_signed   = $signed(reg1) < $signed(reg2);
    assign lt_unsigned = reg1 < reg2;

    // ------------------------------------------------------------------------
    // multiply on magnitudes, sign restored on the full product.
    // ------------------------------------------------------------------------
    assign mul_signed = (op == isa_pkg::op_mul) || (op == isa_pkg::op_mulh);
    assign mag1       = (mul_signed && reg1[isa_pkg::xlen-1]) ? ~reg1 + 1'b1 : reg1;
    assign mag2       = (mul_signed && reg2[isa_pkg::xlen-1]) ? ~reg2 + 1'b1 : reg2;
    assign mag_prod   = {{isa_pkg::xlen{1'b0}}, mag1} * {{isa_pkg::xlen{1'b0}}, mag2};
    assign prod       = (mul_signed && (reg1[isa_pkg::xlen-1] ^ reg2[isa_pkg::xlen-1]))
                      ? ~mag_prod + 1'b1 : mag_prod;

    always_comb begin
        case (op)
            isa_pkg::op_add:   arith_res = reg1 + reg2;
            isa_pkg::op_sub:   arith_res = reg1 - reg2;
            isa_pkg::op_slt:   arith_res = {{(isa_pkg::xlen-1){1'b0}}, lt_signed};
            isa_pkg::op_sltu:  arith_res = {{(isa_pkg::xlen-1){1'b0}}, lt_unsigned};
            isa_pkg::op_mul:   arith_res = prod[isa_pkg::xlen-1:0];
            isa_pkg::op_mulh,
            isa_pkg::op_mulhu: arith_res = prod[2*isa_pkg::xlen-1:isa_pkg::xlen];
            default:           arith_res = '0;   // divides come from the divider.
        endcase
    end

endmodule

//--- hdl/div_iter.sv
module div_iter (
    input  logic                  clk,
    input  logic                  arst_n,
    input  stage_pkg::div_req_t   req,
    output stage_pkg::div_resp_t  resp
);

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_done
    } state_e;

    state_e                                state_q;
    logic [$clog2(isa_pkg::xlen)-1:0]      cnt_q;
    logic [isa_pkg::xlen-1:0]              quo_q;     // dividend bits shift out, quotient in.
    logic [isa_pkg::xlen-1:0]              rem_q;
    logic [isa_pkg::xlen-1:0]              dsor_q;
    logic                                  q_neg_q;
    logic                                  r_neg_q;
    logic                                  dzero_q;
    logic [isa_pkg::xlen-1:0]              dend_mag;
    logic [isa_pkg::xlen-1:0]              dsor_mag;
    logic [isa_pkg::xlen:0]                trial;

    assign dend_mag = (req.is_signed && req.dividend[isa_pkg::xlen-1])
                    ? ~req.dividend + 1'b1 : req.dividend;
    assign dsor_mag = (req.is_signed && req.divisor[isa_pkg::xlen-1])
                    ? ~req.divisor + 1'b1 : req.divisor;

    // restoring step, borrow in the top bit.
    assign trial = {rem_q, quo_q[isa_pkg::xlen-1]} - {1'b0, dsor_q};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (req.start) begin
                        state_q <= st_busy;
                        cnt_q   <= '0;
                    end
                end
                st_busy: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == '1) begin
                        state_q <= st_done;   // all bits resolved.
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle && req.start) begin
            quo_q   <= dend_mag;
            rem_q   <= '0;
            dsor_q  <= dsor_mag;
            q_neg_q <= req.is_signed && (req.dividend[isa_pkg::xlen-1] ^ req.divisor[isa_pkg::xlen-1]);
            r_neg_q <= req.is_signed && req.dividend[isa_pkg::xlen-1];
            dzero_q <= (req.divisor == '0);
        end else if (state_q == st_busy) begin
            if (!trial[isa_pkg::xlen]) begin
                rem_q <= trial[isa_pkg::xlen-1:0];
                quo_q <= {quo_q[isa_pkg::xlen-2:0], 1'b1};
            end else begin
                rem_q <= {rem_q[isa_pkg::xlen-2:0], quo_q[isa_pkg::xlen-1]};
                quo_q <= {quo_q[isa_pkg::xlen-2:0], 1'b0};
            end
        end
    end

    // a zero divisor leaves the dividend magnitude in rem_q.
    assign resp.done      = (state_q == st_done);
    assign resp.quotient  = dzero_q ? '1 : (q_neg_q ? ~quo_q + 1'b1 : quo_q);
    assign resp.remainder = r_neg_q ? ~rem_q + 1'b1 : rem_q;

endmodule

//--- hdl/mem_agu.sv
module mem_agu (
    input  stage_pkg::dispatch_ex_t  dispatch,
    input  logic                     llbit,
    input  stage_pkg::csr_fwd_t      mem_fwd,
    input  stage_pkg::csr_fwd_t      wb_fwd,
    input  logic                     dcache_addr_ok,
    output stage_pkg::dcache_req_t   dcache_req,
    output stage_pkg::ex_mem_t       mem_fields,
    output logic                     stall
);

    logic                             llbit_eff;
    logic                             is_load;
    logic                             is_store;
    logic                             is_sc;
    logic                             sc_ok;
    logic [11:0]                      si12;
    logic [13:0]                      si14;
    logic [isa_pkg::xlen-1:0]         addr;
    logic                             ale;

    // ------------------------------------------------------------------------
    // LL bit, youngest write wins.
    // ------------------------------------------------------------------------
    always_comb begin
        if (mem_fwd.write_en && (mem_fwd.write_addr == isa_pkg::csr_llbctl)) begin
            llbit_eff = mem_fwd.write_data[0];
        end else if (wb_fwd.write_en && (wb_fwd.write_addr == isa_pkg::csr_llbctl)) begin
            llbit_eff = wb_fwd.write_data[0];
        end else begin
            llbit_eff = llbit;
        end
    end

    assign is_load  = dispatch.op inside {isa_pkg::op_ld_b, isa_pkg::op_ld_bu, isa_pkg::op_ld_h,
                                          isa_pkg::op_ld_hu, isa_pkg::op_ld_w, isa_pkg::op_ll_w};
    assign is_store = dispatch.op inside {isa_pkg::op_st_b, isa_pkg::op_st_h, isa_pkg::op_st_w};
    assign is_sc    = (dispatch.op == isa_pkg::op_sc_w);
    assign sc_ok    = is_sc && llbit_eff;

    assign si12 = dispatch.inst[21:10];
    assign si14 = dispatch.inst[23:10];

    always_comb begin
        if (is_load) begin
            addr = dispatch.reg1 + dispatch.reg2;
        end else if (is_store) begin
            addr = dispatch.reg1 + {{20{si12[11]}}, si12};
        end else if (is_sc) begin
            addr = dispatch.reg1 + {{16{si14[13]}}, si14, 2'b00};
        end else begin
            addr = '0;
        end
    end

    always_comb begin
        case (dispatch.op)
            isa_pkg::op_ld_h, isa_pkg::op_ld_hu, isa_pkg::op_st_h: ale = addr[0];
            isa_pkg::op_ld_w, isa_pkg::op_ll_w,
            isa_pkg::op_st_w, isa_pkg::op_sc_w:                    ale = |addr[1:0];
            default:                                               ale = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // cache request
    // ------------------------------------------------------------------------
    always_comb begin
        dcache_req.valid = dispatch.valid && !dispatch.is_exception && !ale
                         && (is_load || is_store || sc_ok);   // failed sc.w stays local.
        dcache_req.op    = is_store || is_sc;
        dcache_req.addr  = addr;
        dcache_req.wstrb = '1;
        dcache_req.wdata = '0;
        case (dispatch.op)
            isa_pkg::op_st_b: begin
                dcache_req.wstrb = 4'b0001 << addr[1:0];
                dcache_req.wdata = {4{dispatch.reg2[7:0]}};
            end
            isa_pkg::op_st_h: begin
                dcache_req.wstrb = addr[1] ? 4'b1100 : 4'b0011;
                dcache_req.wdata = {2{dispatch.reg2[15:0]}};
            end
            isa_pkg::op_st_w, isa_pkg::op_sc_w: dcache_req.wdata = dispatch.reg2;
            default: ;
        endcase
    end

    assign stall = dcache_req.valid && !dcache_addr_ok;

    always_comb begin
        mem_fields             = '0;   // top level fills the rest.
        mem_fields.mem_addr    = addr;
        mem_fields.ale         = ale;
        mem_fields.ld_en       = {dispatch.op == isa_pkg::op_ll_w, dispatch.op == isa_pkg::op_ld_w,
                                  dispatch.op == isa_pkg::op_ld_hu, dispatch.op == isa_pkg::op_ld_h,
                                  dispatch.op == isa_pkg::op_ld_bu, dispatch.op == isa_pkg::op_ld_b};
        mem_fields.st_en       = {sc_ok, dispatch.op == isa_pkg::op_st_w,
                                  dispatch.op == isa_pkg::op_st_h, dispatch.op == isa_pkg::op_st_b};
        mem_fields.llbit_we    = (dispatch.op == isa_pkg::op_ll_w) || sc_ok;
        mem_fields.llbit_wdata = (dispatch.op == isa_pkg::op_ll_w);   // sc.w clears.
    end

endmodule

//--- hdl/ex_stage.sv
module ex_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  stage_pkg::dispatch_ex_t  dispatch,
    input  logic                     llbit,
    input  stage_pkg::csr_fwd_t      mem_fwd,
    input  stage_pkg::csr_fwd_t      wb_fwd,
    input  logic                     dcache_addr_ok,
    output stage_pkg::ex_mem_t       ex_mem,
    output stage_pkg::dcache_req_t   dcache_req,
    output logic                     pause
);

    logic [isa_pkg::xlen-1:0]   logic_res;
    logic [isa_pkg::xlen-1:0]   shift_res;
    logic [isa_pkg::xlen-1:0]   arith_res;
    stage_pkg::div_req_t        div_req;
    stage_pkg::div_resp_t       div_resp;
    stage_pkg::ex_mem_t         mem_fields;
    logic                       mem_stall;
    logic                       is_div;
    logic                       is_mod;
    logic                       div_stall;
    logic [isa_pkg::xlen-1:0]   wb_data;

    alu_int u_alu (
        .op        (dispatch.op),
        .reg1      (dispatch.reg1),
        .reg2      (dispatch.reg2),
        .logic_res (logic_res),
        .shift_res (shift_res),
        .arith_res (arith_res)
    );

    // ------------------------------------------------------------------------
    // divide control
    // ------------------------------------------------------------------------
    assign is_div = (dispatch.op == isa_pkg::op_div) || (dispatch.op == isa_pkg::op_divu);
    assign is_mod = (dispatch.op == isa_pkg::op_mod) || (dispatch.op == isa_pkg::op_modu);

    assign div_stall         = dispatch.valid && (is_div || is_mod) && !div_resp.done;
    assign div_req.start     = div_stall;   // held until the done cycle.
    assign div_req.is_signed = (dispatch.op == isa_pkg::op_div) || (dispatch.op == isa_pkg::op_mod);
    assign div_req.dividend  = dispatch.reg1;
    assign div_req.divisor   = dispatch.reg2;

    div_iter u_div (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (div_req),
        .resp   (div_resp)
    );

    mem_agu u_agu (
        .dispatch       (dispatch),
        .llbit          (llbit),
        .mem_fwd        (mem_fwd),
        .wb_fwd         (wb_fwd),
        .dcache_addr_ok (dcache_addr_ok),
        .dcache_req     (dcache_req),
        .mem_fields     (mem_fields),
        .stall          (mem_stall)
    );

    assign pause = div_stall || mem_stall;

    always_comb begin
        case (dispatch.sel)
            isa_pkg::sel_logic: wb_data = logic_res;
            isa_pkg::sel_shift: wb_data = shift_res;
            isa_pkg::sel_arith: begin
                if (is_div) begin
                    wb_data = div_resp.quotient;
                end else if (is_mod) begin
                    wb_data = div_resp.remainder;
                end else begin
                    wb_data = arith_res;
                end
            end
            // sc.w success bit equals the effective LL bit.
            isa_pkg::sel_load_store: wb_data = (dispatch.op == isa_pkg::op_sc_w)
                ? {{(isa_pkg::xlen-1){1'b0}}, mem_fields.st_en[stage_pkg::st_kinds-1]} : '0;
            default: wb_data = '0;
        endcase
    end

    always_comb begin
        ex_mem                = mem_fields;
        ex_mem.valid          = dispatch.valid;
        ex_mem.pc             = dispatch.pc;
        ex_mem.reg_write_en   = dispatch.reg_write_en;
        ex_mem.reg_write_addr = dispatch.reg_write_addr;
        ex_mem.reg_write_data = wb_data;
    end

endmodule

//--- testbench/tb_ex_stage.sv
module tb_ex_stage;

    localparam int div_timeout = 64;

    logic                     clk;
    logic                     arst_n;
    stage_pkg::dispatch_ex_t  dispatch;
    logic                     llbit;
    stage_pkg::csr_fwd_t      mem_fwd;
    stage_pkg::csr_fwd_t      wb_fwd;
    logic                     dcache_addr_ok;
    stage_pkg::ex_mem_t       ex_mem;
    stage_pkg::dcache_req_t   dcache_req;
    logic                     pause;

    int                       errors = 0;
    int                       checks = 0;
    logic [31:0]              lfsr_state = 32'h57a2_4990;

    ex_stage UUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .dispatch       (dispatch),
        .llbit          (llbit),
        .mem_fwd        (mem_fwd),
        .wb_fwd         (wb_fwd),
        .dcache_addr_ok (dcache_addr_ok),
        .ex_mem         (ex_mem),
        .dcache_req     (dcache_req),
        .pause          (pause)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1.
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic logic [31:0] rand_word();
        return rand_bits(32);
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout in %s: pause never fell", what);
        errors++;
    endtask

    task automatic issue(input isa_pkg::alu_op_e op, input isa_pkg::alu_sel_e sel,
                         input logic [31:0] a, input logic [31:0] b, input logic [31:0] inst);
        logic [31:0] wb;
        @(negedge clk);
        wb                      = rand_bits(6);
        dispatch.valid          = 1'b1;
        dispatch.pc             = rand_bits(30) << 2;
        dispatch.inst           = inst;
        dispatch.op             = op;
        dispatch.sel            = sel;
        dispatch.reg1           = a;
        dispatch.reg2           = b;
        dispatch.reg_write_en   = wb[5];
        dispatch.reg_write_addr = wb[4:0];
        dispatch.is_exception   = 1'b0;
        #1;   // let the combinational outputs settle.
    endtask

    task automatic drive_idle();
        dispatch.valid = 1'b0;
        dispatch.op    = isa_pkg::op_nop;
        dispatch.sel   = isa_pkg::sel_none;
    endtask

    task automatic passthrough_fields(input string name);
        check({name, " valid"}, 32'h1, 32'(ex_mem.valid));
        check({name, " pc"}, dispatch.pc, ex_mem.pc);
        check({name, " wen"}, 32'(dispatch.reg_write_en), 32'(ex_mem.reg_write_en));
        check({name, " waddr"}, 32'(dispatch.reg_write_addr), 32'(ex_mem.reg_write_addr));
    endtask

    function automatic stage_pkg::csr_fwd_t llbctl_write(input logic en, input logic value);
        stage_pkg::csr_fwd_t f;
        f.write_en   = en;
        f.write_addr = isa_pkg::csr_llbctl;
        f.write_data = {31'b0, value};
        return f;
    endfunction

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic isa_pkg::alu_sel_e sel_for(input isa_pkg::alu_op_e op);
        if (op inside {isa_pkg::op_or, isa_pkg::op_nor, isa_pkg::op_and, isa_pkg::op_xor,
                       isa_pkg::op_lu12i}) return isa_pkg::sel_logic;
        if (op inside {isa_pkg::op_sll, isa_pkg::op_srl, isa_pkg::op_sra})
            return isa_pkg::sel_shift;
        return isa_pkg::sel_arith;
    endfunction

    function automatic logic [31:0] alu_model(input isa_pkg::alu_op_e op,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [63:0] sp;
        logic [63:0] up;
        sp = {{32{a[31]}}, a} * {{32{b[31]}}, b};   // low 64 bits equal the signed product.
        up = {32'b0, a} * {32'b0, b};
        case (op)
            isa_pkg::op_or, isa_pkg::op_lu12i: return a | b;
            isa_pkg::op_nor:   return ~(a | b);
            isa_pkg::op_and:   return a & b;
            isa_pkg::op_xor:   return a ^ b;
            isa_pkg::op_sll:   return a << b[4:0];
            isa_pkg::op_srl:   return a >> b[4:0];
            isa_pkg::op_sra:   return $unsigned($signed(a) >>> b[4:0]);
            isa_pkg::op_add:   return a + b;
            isa_pkg::op_sub:   return a - b;
            isa_pkg::op_slt:   return {31'b0, $signed(a) < $signed(b)};
            isa_pkg::op_sltu:  return {31'b0, a < b};
            isa_pkg::op_mul:   return sp[31:0];
            isa_pkg::op_mulh:  return sp[63:32];
            isa_pkg::op_mulhu: return up[63:32];
            default:           return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] div_model(input isa_pkg::alu_op_e op,
                                              input logic [31:0] a, input logic [31:0] b);
        logic        sgn;
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] q;
        logic [31:0] r;
        sgn = (op == isa_pkg::op_div) || (op == isa_pkg::op_mod);
        if (b == 32'h0) begin
            q = '1;
            r = a;
        end else begin
            ma = (sgn && a[31]) ? -a : a;
            mb = (sgn && b[31]) ? -b : b;
            q  = ma / mb;
            r  = ma % mb;
            if (sgn && (a[31] ^ b[31])) q = -q;
            if (sgn && a[31]) r = -r;   // remainder follows the dividend.
        end
        return (op == isa_pkg::op_div || op == isa_pkg::op_divu) ? q : r;
    endfunction

    task automatic check_mem(input string name, input isa_pkg::alu_op_e op,
                             input logic [31:0] a, input logic [31:0] b, input logic [31:0] inst);
        logic [31:0] addr;
        logic        is_st;
        logic        ale;
        logic [5:0]  ld;
        logic [3:0]  st;
        logic [3:0]  strb;
        logic [31:0] wdata;
        is_st = op inside {isa_pkg::op_st_b, isa_pkg::op_st_h, isa_pkg::op_st_w};
        addr  = is_st ? a + {{20{inst[21]}}, inst[21:10]} : a + b;
        ld    = 6'b000001 << (int'(op) - int'(isa_pkg::op_ld_b));
        st    = 4'b0001 << (int'(op) - int'(isa_pkg::op_st_b));
        if (is_st) ld = '0;
        else st = '0;
        ale   = 1'b0;
        if (op inside {isa_pkg::op_ld_h, isa_pkg::op_ld_hu, isa_pkg::op_st_h}) ale = addr[0];
        if (op inside {isa_pkg::op_ld_w, isa_pkg::op_ll_w, isa_pkg::op_st_w})
            ale = addr[1:0] != 2'b00;
        strb  = 4'hf;
        wdata = b;
        if (op == isa_pkg::op_st_b) begin
            strb  = 4'b0001 << addr[1:0];
            wdata = {4{b[7:0]}};
        end else if (op == isa_pkg::op_st_h) begin
            strb  = addr[1] ? 4'b1100 : 4'b0011;
            wdata = {2{b[15:0]}};
        end
        check({name, " addr"}, addr, ex_mem.mem_addr);
        check({name, " req addr"}, addr, dcache_req.addr);
        check({name, " ld_en"}, 32'(ld), 32'(ex_mem.ld_en));
        check({name, " st_en"}, 32'(st), 32'(ex_mem.st_en));
        check({name, " ale"}, 32'(ale), 32'(ex_mem.ale));
        check({name, " req valid"}, 32'(!ale), 32'(dcache_req.valid));
        check({name, " req op"}, 32'(is_st), 32'(dcache_req.op));
        if (is_st && !ale) begin
            check({name, " wstrb"}, 32'(strb), 32'(dcache_req.wstrb));
            check({name, " wdata"}, wdata, dcache_req.wdata);
        end
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic alu_ops();
        isa_pkg::alu_op_e op;
        logic [31:0]      a;
        logic [31:0]      b;
        for (int n = 0; n < 8; n++) begin
            for (int k = int'(isa_pkg::op_or); k <= int'(isa_pkg::op_mulhu); k++) begin
                op = isa_pkg::alu_op_e'(k);
                a  = rand_word();
                b  = rand_word();
                issue(op, sel_for(op), a, b, 32'h0);
                check($sformatf("alu %s", op.name()), alu_model(op, a, b), ex_mem.reg_write_data);
                check($sformatf("alu %s pause", op.name()), 32'h0, 32'(pause));
                passthrough_fields($sformatf("alu %s", op.name()));
            end
        end
        drive_idle();
    endtask

    task automatic run_div(input isa_pkg::alu_op_e op, input logic [31:0] a,
                           input logic [31:0] b);
        int cycles;
        issue(op, isa_pkg::sel_arith, a, b, 32'h0);
        check($sformatf("%s pause", op.name()), 32'h1, 32'(pause));
        cycles = 0;
        while (pause && cycles < div_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (pause) begin
            report_timeout(op.name());
        end else begin
            check($sformatf("%s %h %h", op.name(), a, b), div_model(op, a, b),
                  ex_mem.reg_write_data);
        end
        drive_idle();   // must drop before the done cycle ends.
    endtask

    task automatic divide_ops();
        isa_pkg::alu_op_e op;
        logic [31:0]      w;
        for (int k = int'(isa_pkg::op_div); k <= int'(isa_pkg::op_modu); k++) begin
            op = isa_pkg::alu_op_e'(k);
            for (int n = 0; n < 4; n++) begin
                w = rand_bits(5);
                run_div(op, rand_word(), rand_word() >> w[4:0]);
            end
            run_div(op, rand_word(), 32'h0);
            run_div(op, 32'h8000_0000, 32'hffff_ffff);
        end
    endtask

    task automatic load_store_ops();
        isa_pkg::alu_op_e op;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      inst;
        for (int k = int'(isa_pkg::op_ld_b); k <= int'(isa_pkg::op_st_w); k++) begin
            op = isa_pkg::alu_op_e'(k);
            for (int m = 0; m < 4; m++) begin
                a    = (rand_word() & ~32'h3) | 32'(m);
                b    = rand_word() & 32'h0000_0ffc;
                inst = rand_word() & ~32'h0000_0c00;   // keep si12 word aligned.
                issue(op, isa_pkg::sel_load_store, a, b, inst);
                check_mem($sformatf("%s lane %0d", op.name(), m), op, a, b, inst);
            end
        end
        // an earlier exception suppresses the request.
        issue(isa_pkg::op_st_w, isa_pkg::sel_load_store, rand_word() & ~32'h3, rand_word(),
              32'h0);
        dispatch.is_exception = 1'b1;
        #1;
        check("st.w exception req valid", 32'h0, 32'(dcache_req.valid));
        drive_idle();
    endtask

    task automatic cache_backpressure();
        @(negedge clk);
        dcache_addr_ok = 1'b0;
        issue(isa_pkg::op_ld_w, isa_pkg::sel_load_store, rand_word() & ~32'h3, 32'h40, 32'h0);
        check("backpressure pause", 32'h1, 32'(pause));
        for (int n = 0; n < 5; n++) begin
            @(negedge clk);
            check("backpressure held pause", 32'h1, 32'(pause));
            check("backpressure held valid", 32'h1, 32'(dcache_req.valid));
        end
        dcache_addr_ok = 1'b1;
        #1;
        check("backpressure release", 32'h0, 32'(pause));
        drive_idle();
    endtask

    task automatic sc_case(input string name, input logic bit_in,
                           input stage_pkg::csr_fwd_t mf, input stage_pkg::csr_fwd_t wf,
                           input logic ok);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] inst;
        @(negedge clk);
        llbit   = bit_in;
        mem_fwd = mf;
        wb_fwd  = wf;
        a       = rand_word() & ~32'h3;
        b       = rand_word();
        inst    = rand_word();
        issue(isa_pkg::op_sc_w, isa_pkg::sel_load_store, a, b, inst);
        check({name, " addr"}, a + {{16{inst[23]}}, inst[23:10], 2'b00}, ex_mem.mem_addr);
        check({name, " req valid"}, 32'(ok), 32'(dcache_req.valid));
        check({name, " result"}, 32'(ok), ex_mem.reg_write_data);
        check({name, " st_en"}, ok ? 32'h8 : 32'h0, 32'(ex_mem.st_en));
        check({name, " llbit_we"}, 32'(ok), 32'(ex_mem.llbit_we));
        check({name, " llbit_wdata"}, 32'h0, 32'(ex_mem.llbit_wdata));
        if (ok) check({name, " wdata"}, b, dcache_req.wdata);
    endtask

    task automatic ll_sc_ops();
        stage_pkg::csr_fwd_t other;
        other            = llbctl_write(1'b1, 1'b1);
        other.write_addr = ~isa_pkg::csr_llbctl;
        issue(isa_pkg::op_ll_w, isa_pkg::sel_load_store, 32'h0000_1000, 32'h20, 32'h0);
        check("ll.w llbit_we", 32'h1, 32'(ex_mem.llbit_we));
        check("ll.w llbit_wdata", 32'h1, 32'(ex_mem.llbit_wdata));
        sc_case("sc.w llbit set", 1'b1, '0, '0, 1'b1);
        sc_case("sc.w llbit clear", 1'b0, '0, '0, 1'b0);
        sc_case("sc.w wb fwd", 1'b0, '0, llbctl_write(1'b1, 1'b1), 1'b1);
        sc_case("sc.w wb fwd disabled", 1'b0, '0, llbctl_write(1'b0, 1'b1), 1'b0);
        sc_case("sc.w mem fwd other csr", 1'b0, other, '0, 1'b0);
        sc_case("sc.w mem over wb set", 1'b0, llbctl_write(1'b1, 1'b1),
                llbctl_write(1'b1, 1'b0), 1'b1);
        sc_case("sc.w mem over wb clear", 1'b1, llbctl_write(1'b1, 1'b0),
                llbctl_write(1'b1, 1'b1), 1'b0);
        drive_idle();
        llbit   = 1'b0;
        mem_fwd = '0;
        wb_fwd  = '0;
    endtask

    // ------------------------------------------------------------------------
    // sequence
    // ------------------------------------------------------------------------
    initial begin
        dispatch       = '0;
        llbit          = 1'b0;
        mem_fwd        = '0;
        wb_fwd         = '0;
        dcache_addr_ok = 1'b1;
        arst_n         = 1'b0;
        drive_idle();
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #1;
        check("reset pause", 32'h0, 32'(pause));
        check("reset req valid", 32'h0, 32'(dcache_req.valid));
        check("reset ex_mem valid", 32'h0, 32'(ex_mem.valid));
        alu_ops();
        divide_ops();
        load_store_ops();
        cache_backpressure();
        ll_sc_ops();
        @(negedge clk);
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- ex_stage.f
hdl/isa_pkg.sv
hdl/stage_pkg.sv
hdl/alu_int.sv
hdl/div_iter.sv
hdl/mem_agu.sv
hdl/ex_stage.sv
testbench/tb_ex_stage.sv

//--- run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f ex_stage.f --top-module tb_ex_stage -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_ex_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
exit 1
